// ==== logic/cmd_decoder.sv ====
`timescale 1ns/10ps

`include "stack_engine_macros.svh"

module cmd_decoder
	import cmd_pkg::*, stack_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic fetch_start,
	input logic word_valid,
	input cmd_word_t word,
	input levels_t levels,
	output logic rd_en,
	output logic fetch_done,
	output decoded_cmd_t cmd
);

	typedef enum logic [1:0] {
		START = 2'b00,
		GET = 2'b01,
		CHECK = 2'b10,
		END = 2'b11
	} state_t;

	state_t state;
	state_t next_state;
	decoded_cmd_t next_cmd;
	level_t word_level;

	assign word_level = levels[word.stack];
	assign rd_en = (state == GET);
	assign fetch_done = (state == END);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= START;
			cmd <= '0;
		end else begin
			state <= next_state;
			cmd <= next_cmd;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			START:
				if (fetch_start)
					next_state = GET;
			GET:
				if (word_valid)
					next_state = CHECK;
			CHECK:
				next_state = END;
			END:
				next_state = START;
		endcase
	end

	// Errors keep the last good fields and only update the code
	always_comb begin
		next_cmd = cmd;
		if (state == CHECK) begin
			case (word.opcode)
				OP_POP:
					if (word.value <= cmd_value_t'(`POP_MAX))
						next_cmd = '{word.opcode, word.stack, word.value, ERR_NONE};
					else
						next_cmd.error = ERR_RANGE;
				OP_DUP:
					if (word_level < level_t'(`STACK_DEPTH))
						next_cmd = '{word.opcode, word.stack, '0, ERR_NONE};
					else
						next_cmd.error = ERR_FULL;
				OP_PUSH:
					if (word_level < level_t'(`STACK_DEPTH))
						next_cmd = '{word.opcode, word.stack, word.value, ERR_NONE};
					else
						next_cmd.error = ERR_FULL;
				OP_CLEAR:
					next_cmd = '{word.opcode, '0, '0, ERR_NONE};
				default:
					next_cmd.error = ERR_OPCODE;
			endcase
		end
	end

endmodule

// ==== logic/cmd_pkg.sv ====
`include "stack_engine_macros.svh"

package cmd_pkg;

	typedef logic [`OPCODE_WIDTH-1:0] opcode_t;
	typedef logic [`STACK_INDEX_WIDTH-1:0] stack_idx_t;
	typedef logic [`VALUE_WIDTH-1:0] cmd_value_t;

	localparam opcode_t OP_POP = opcode_t'(0);
	localparam opcode_t OP_DUP = opcode_t'(1);
	localparam opcode_t OP_PUSH = opcode_t'(2);
	localparam opcode_t OP_CLEAR = opcode_t'(3);

	typedef enum logic [1:0] {
		ERR_NONE = 2'd0,
		ERR_OPCODE = 2'd1,
		ERR_RANGE = 2'd2,
		ERR_FULL = 2'd3
	} err_t;

	// Host word, opcode in the top byte
	typedef struct packed {
		opcode_t opcode;
		stack_idx_t stack;
		cmd_value_t value;
	} cmd_word_t;

	typedef struct packed {
		opcode_t opcode;
		stack_idx_t stack;
		cmd_value_t value;
		err_t error;
	} decoded_cmd_t;

endpackage

// ==== logic/cmd_port.sv ====
`timescale 1ns/10ps

module cmd_port
	import cmd_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cmd_req,
	input cmd_word_t cmd_word,
	output logic cmd_ack,
	input logic rd_en,
	output logic word_valid,
	output cmd_word_t word
);

	logic accept;

	// Only take a word into an empty register, once the last ack has dropped
	assign accept = cmd_req && !cmd_ack && !word_valid;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cmd_ack <= 1'b0;
		end else if (accept) begin
			cmd_ack <= 1'b1;
		end else if (cmd_ack && !cmd_req) begin
			cmd_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			word_valid <= 1'b0;
		end else if (accept) begin
			word_valid <= 1'b1;
		end else if (rd_en && word_valid) begin
			word_valid <= 1'b0;
		end
	end

	// Holding register, left as is until the next word arrives
	always_ff @(posedge clk) begin
		if (accept)
			word <= cmd_word;
	end

endmodule

// ==== logic/engine_control.sv ====
`timescale 1ns/10ps

module engine_control
	import cmd_pkg::*, stack_pkg::*;
(
	input logic clk,
	input logic rst,
	output logic fetch_start,
	input logic fetch_done,
	input decoded_cmd_t cmd,
	input levels_t levels,
	input tops_t tops,
	output logic exec,
	output logic res_req,
	output result_t res,
	input logic res_ack
);

	typedef enum logic [2:0] {
		START,
		FETCH,
		EXEC,
		REPORT,
		RELEASE
	} state_t;

	state_t state;
	state_t next_state;

	assign fetch_start = (state == START);
	assign exec = (state == EXEC) && (cmd.error == ERR_NONE);

	// Comes out of reset as if a handshake just closed
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= RELEASE;
			res_req <= 1'b0;
		end else begin
			state <= next_state;
			res_req <= (next_state == REPORT);
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			START:
				next_state = FETCH;
			FETCH:
				if (fetch_done)
					next_state = EXEC;
			EXEC:
				next_state = REPORT;
			REPORT:
				if (res_ack)
					next_state = RELEASE;
			RELEASE:
				if (!res_ack)
					next_state = START;
			default:
				next_state = RELEASE;
		endcase
	end

	// Built from bank and decoder registers, none of which move
	// until the next fetch, so the record holds through the handshake
	always_comb begin
		res.error = cmd.error;
		res.opcode = cmd.opcode;
		res.stack = cmd.stack;
		res.level = levels[cmd.stack];
		res.top = tops[cmd.stack];
	end

endmodule

// ==== logic/stack_bank.sv ====
`timescale 1ns/10ps

`include "stack_engine_macros.svh"

module stack_bank
	import cmd_pkg::*, stack_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic exec,
	input decoded_cmd_t cmd,
	output levels_t levels,
	output tops_t tops
);

	value_t mem [`STACK_COUNT][`STACK_DEPTH];
	level_t cur_level;
	logic do_write;
	value_t wr_data;

	assign cur_level = levels[cmd.stack];
	assign do_write = exec && (cmd.opcode == OP_DUP || cmd.opcode == OP_PUSH);

	// DUP copies the current top, which is already 0 on an empty stack
	assign wr_data = (cmd.opcode == OP_DUP) ? tops[cmd.stack] : value_t'(cmd.value);

	always_comb begin
		for (int i = 0; i < `STACK_COUNT; i++) begin
			if (levels[i] == '0)
				tops[i] = '0;
			else
				tops[i] = mem[i][levels[i] - 1'b1];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			levels <= '0;
		end else if (exec) begin
			case (cmd.opcode)
				OP_POP:
					if ({1'b0, cur_level} > cmd.value)
						levels[cmd.stack] <= cur_level - level_t'(cmd.value);
					else
						levels[cmd.stack] <= '0;
				OP_DUP, OP_PUSH:
					levels[cmd.stack] <= cur_level + 1'b1;
				OP_CLEAR:
					levels <= '0;
				default:
					levels <= levels;
			endcase
		end
	end

	// Free slot sits at the current level, fullness already checked upstream
	always_ff @(posedge clk) begin
		if (do_write)
			mem[cmd.stack][cur_level] <= wr_data;
	end

endmodule

// ==== logic/stack_engine.sv ====
`timescale 1ns/10ps

module stack_engine
	import cmd_pkg::*, stack_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cmd_req,
	input cmd_word_t cmd_word,
	output logic cmd_ack,
	output logic res_req,
	output result_t res,
	input logic res_ack
);

	logic rd_en;
	logic word_valid;
	cmd_word_t word;
	logic fetch_start;
	logic fetch_done;
	decoded_cmd_t cmd;
	logic exec;
	levels_t levels;
	tops_t tops;

	cmd_port u_cmd_port (
		.clk(clk),
		.rst(rst),
		.cmd_req(cmd_req),
		.cmd_word(cmd_word),
		.cmd_ack(cmd_ack),
		.rd_en(rd_en),
		.word_valid(word_valid),
		.word(word)
	);

	cmd_decoder u_cmd_decoder (
		.clk(clk),
		.rst(rst),
		.fetch_start(fetch_start),
		.word_valid(word_valid),
		.word(word),
		.levels(levels),
		.rd_en(rd_en),
		.fetch_done(fetch_done),
		.cmd(cmd)
	);

	stack_bank u_stack_bank (
		.clk(clk),
		.rst(rst),
		.exec(exec),
		.cmd(cmd),
		.levels(levels),
		.tops(tops)
	);

	engine_control u_engine_control (
		.clk(clk),
		.rst(rst),
		.fetch_start(fetch_start),
		.fetch_done(fetch_done),
		.cmd(cmd),
		.levels(levels),
		.tops(tops),
		.exec(exec),
		.res_req(res_req),
		.res(res),
		.res_ack(res_ack)
	);

endmodule

// ==== logic/stack_engine_macros.svh ====
`ifndef STACK_ENGINE_MACROS_SVH
`define STACK_ENGINE_MACROS_SVH

// Stack bank geometry
`define STACK_COUNT 8
`define STACK_DEPTH 15
`define VALUE_WIDTH 5

// Largest count a single POP may ask for
`define POP_MAX 10

// Field widths derived from the geometry
`define OPCODE_WIDTH 8
`define STACK_INDEX_WIDTH $clog2(`STACK_COUNT)

// A level of 0 up to STACK_DEPTH inclusive
`define LEVEL_WIDTH $clog2(`STACK_DEPTH + 1)

`endif

// ==== logic/stack_pkg.sv ====
`include "stack_engine_macros.svh"

package stack_pkg;

	import cmd_pkg::*;

	typedef logic [`LEVEL_WIDTH-1:0] level_t;
	typedef logic [`VALUE_WIDTH-1:0] value_t;

	// One entry per stack, stack 0 in the low bits
	typedef level_t [`STACK_COUNT-1:0] levels_t;
	typedef value_t [`STACK_COUNT-1:0] tops_t;

	// Record returned to the host
	typedef struct packed {
		err_t error;
		opcode_t opcode;
		stack_idx_t stack;
		level_t level;
		value_t top;
	} result_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stack_engine testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	-f stack_engine.f \
	--top-module stack_engine_tb \
	-o stack_engine_sim

./obj_dir/stack_engine_sim | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi

echo "Simulation passed"

// ==== stack_engine.f ====
+incdir+logic
logic/cmd_pkg.sv
logic/stack_pkg.sv
logic/cmd_port.sv
logic/cmd_decoder.sv
logic/stack_bank.sv
logic/engine_control.sv
logic/stack_engine.sv
test/stack_engine_tb.sv

// ==== test/stack_engine_tb.sv ====
`timescale 1ns/10ps

`include "stack_engine_macros.svh"

module stack_engine_tb
	import cmd_pkg::*, stack_pkg::*;
();

	localparam time CLK_PERIOD = 100;
	localparam time DRIVE_DELAY = 10;
	localparam int WAIT_LIMIT = 100;

	logic clk;
	logic rst;
	logic cmd_req;
	cmd_word_t cmd_word;
	logic cmd_ack;
	logic res_req;
	result_t res;
	logic res_ack;

	integer seed;
	int value_errors;
	int other_errors;
	result_t expected_q[$];

	// Reference stacks
	value_t ref_mem [`STACK_COUNT][`STACK_DEPTH];
	int ref_level [`STACK_COUNT];
	opcode_t last_op;
	stack_idx_t last_stack;

	stack_engine DUT (
		.clk(clk),
		.rst(rst),
		.cmd_req(cmd_req),
		.cmd_word(cmd_word),
		.cmd_ack(cmd_ack),
		.res_req(res_req),
		.res(res),
		.res_ack(res_ack)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task finish_run;
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	task report_timeout(input string what);
		other_errors++;
		$display("Timeout at %0t while waiting for %s", $time, what);
		finish_run();
	endtask

	task next_cycle;
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task check_value(input string name, input int got, input int exp);
		assert (got == exp) else begin
			value_errors++;
			$display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	function int rand_below(input int n);
		return {$random(seed)} % n;
	endfunction

	function cmd_word_t make_word(input opcode_t op, input int stack, input int value);
		cmd_word_t w;
		w.opcode = op;
		w.stack = stack_idx_t'(stack);
		w.value = cmd_value_t'(value);
		return w;
	endfunction

	function value_t ref_top(input int s);
		if (ref_level[s] == 0)
			return '0;
		else
			return ref_mem[s][ref_level[s] - 1];
	endfunction

	// Apply one command to the reference stacks and build the expected record
	task predict_result(input cmd_word_t w, output result_t exp);
		err_t err;
		int lvl;
		int i;
		err = ERR_NONE;
		lvl = ref_level[w.stack];
		case (w.opcode)
			OP_POP: begin
				if (int'(w.value) > `POP_MAX)
					err = ERR_RANGE;
				else if (lvl > int'(w.value))
					ref_level[w.stack] = lvl - int'(w.value);
				else
					ref_level[w.stack] = 0;
			end
			OP_DUP, OP_PUSH: begin
				if (lvl == `STACK_DEPTH) begin
					err = ERR_FULL;
				end else begin
					if (w.opcode == OP_PUSH)
						ref_mem[w.stack][lvl] = w.value;
					else
						ref_mem[w.stack][lvl] = ref_top(w.stack);
					ref_level[w.stack] = lvl + 1;
				end
			end
			OP_CLEAR:
				for (i = 0; i < `STACK_COUNT; i++)
					ref_level[i] = 0;
			default:
				err = ERR_OPCODE;
		endcase
		// Failed commands report the last good command's stack
		if (err == ERR_NONE) begin
			last_op = w.opcode;
			last_stack = (w.opcode == OP_CLEAR) ? '0 : w.stack;
		end
		exp.error = err;
		exp.opcode = last_op;
		exp.stack = last_stack;
		exp.level = level_t'(ref_level[last_stack]);
		exp.top = ref_top(last_stack);
	endtask

	task send_cmd(input cmd_word_t w);
		result_t exp;
		int count;
		predict_result(w, exp);
		expected_q.push_back(exp);
		cmd_word = w;
		cmd_req = 1'b1;
		count = 0;
		while (!cmd_ack) begin
			if (count == WAIT_LIMIT)
				report_timeout("cmd_ack to rise");
			next_cycle();
			count++;
		end
		cmd_req = 1'b0;
		count = 0;
		while (cmd_ack) begin
			if (count == WAIT_LIMIT)
				report_timeout("cmd_ack to fall");
			next_cycle();
			count++;
		end
	endtask

	task collect_result(input int hold);
		result_t got;
		result_t exp;
		int count;
		count = 0;
		while (!res_req) begin
			if (count == WAIT_LIMIT)
				report_timeout("res_req to rise");
			next_cycle();
			count++;
		end
		got = res;
		// Ack held back so the record stays put and no new word is taken
		for (int i = 0; i < hold; i++) begin
			next_cycle();
			check_value("res_req", int'(res_req), 1);
			check_value("res", int'(res), int'(got));
			check_value("cmd_ack", int'(cmd_ack), 0);
		end
		res_ack = 1'b1;
		count = 0;
		while (res_req) begin
			if (count == WAIT_LIMIT)
				report_timeout("res_req to fall");
			next_cycle();
			count++;
		end
		res_ack = 1'b0;
		exp = expected_q.pop_front();
		check_value("res.error", int'(got.error), int'(exp.error));
		check_value("res.opcode", int'(got.opcode), int'(exp.opcode));
		check_value("res.stack", int'(got.stack), int'(exp.stack));
		check_value("res.level", int'(got.level), int'(exp.level));
		check_value("res.top", int'(got.top), int'(exp.top));
	endtask

	task run_cmd(input opcode_t op, input int stack, input int value);
		send_cmd(make_word(op, stack, value));
		collect_result(0);
	endtask

	initial begin
		seed = 32'h0331641f;
		value_errors = 0;
		other_errors = 0;
		rst = 1'b0;
		cmd_req = 1'b0;
		cmd_word = '0;
		res_ack = 1'b0;
		last_op = OP_POP;
		last_stack = '0;
		for (int s = 0; s < `STACK_COUNT; s++) begin
			ref_level[s] = 0;
			for (int d = 0; d < `STACK_DEPTH; d++)
				ref_mem[s][d] = '0;
		end
		repeat (8) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b1;
		next_cycle();
		check_value("cmd_ack", int'(cmd_ack), 0);
		check_value("res_req", int'(res_req), 0);

		for (int i = 0; i < 24; i++)
			run_cmd(OP_PUSH, rand_below(8), rand_below(32));

		run_cmd(OP_CLEAR, 5, 9);
		for (int s = 0; s < `STACK_COUNT; s++)
			run_cmd(OP_POP, s, 0);

		// DUP on an empty stack and on a pushed value
		run_cmd(OP_DUP, 2, 7);
		run_cmd(OP_PUSH, 2, 17);
		run_cmd(OP_DUP, 2, 0);

		// Fill stack 5 and try to go past full
		for (int i = 0; i < `STACK_DEPTH; i++)
			run_cmd(OP_PUSH, 5, rand_below(32));
		run_cmd(OP_DUP, 5, 0);
		run_cmd(OP_PUSH, 5, 3);
		run_cmd(OP_POP, 5, 0);

		// Partial pop, then a pop past empty
		run_cmd(OP_POP, 5, 4);
		run_cmd(OP_POP, 2, `POP_MAX);

		for (int i = 0; i < 12; i++)
			run_cmd(OP_POP, rand_below(8), rand_below(`POP_MAX + 1));
		for (int i = 0; i < 4; i++)
			run_cmd(OP_POP, rand_below(8), `POP_MAX + 1 + rand_below(21));

		for (int i = 0; i < 6; i++) begin
			run_cmd(opcode_t'(4 + rand_below(252)), rand_below(8), rand_below(32));
			run_cmd(OP_PUSH, rand_below(8), rand_below(32));
		end

		// Back-pressure with a waiting word and a third blocked request
		for (int i = 0; i < 3; i++) begin
			send_cmd(make_word(OP_PUSH, rand_below(8), rand_below(32)));
			send_cmd(make_word(OP_DUP, rand_below(8), 0));
			fork
				send_cmd(make_word(OP_POP, rand_below(8), rand_below(4)));
				collect_result(1 + rand_below(8));
			join
			collect_result(rand_below(4));
			collect_result(0);
		end

		for (int i = 0; i < 10; i++) begin
			next_cycle();
			check_value("res_req", int'(res_req), 0);
		end
		if (expected_q.size() != 0) begin
			other_errors++;
			$display("%0d commands never returned a record", expected_q.size());
		end
		finish_run();
	end

endmodule
